// ==== Bender.yml ====
package:
  name: load_store_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lsu_pkg.sv
      - verilog/ls_issue.sv
      - verilog/data_bank.sv
      - verilog/load_writeback.sv
      - verilog/load_store_unit.sv
  - target: test
    include_dirs:
      - verilog
      - tests
    files:
      - tests/tb_load_store_unit.sv

// ==== flist.f ====
+incdir+verilog
+incdir+tests
verilog/lsu_pkg.sv
verilog/ls_issue.sv
verilog/data_bank.sv
verilog/load_writeback.sv
verilog/load_store_unit.sv
tests/tb_load_store_unit.sv

// ==== tests/tb_lsu_tasks.svh ====
// Issue, wait and compare tasks for the load/store unit testbench
// Uses the DUT signals, counters and TIMEOUT of the module that includes it
`ifndef TB_LSU_TASKS_SVH
`define TB_LSU_TASKS_SVH

// One clock, then settle past the edge
task automatic step();
    @(posedge clk);
    #1;
endtask

////////////////////////////////////////////////////////////
// Compare tasks

task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_id(input string name, input logic [`LSU_ID_W-1:0] got,
                        input logic [`LSU_ID_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_exc(input string name, input ls_exc_code_e got, input ls_exc_code_e exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s got %s (%0d) expected %s (%0d)",
                 $time, name, got.name(), got, exp.name(), exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic check_latency(input int acc, input int done);
    checks++;
    if (done - acc != 2) begin
        errors++;
        $display("Load accepted in cycle %0d wrote back in cycle %0d, two cycles expected",
                 acc, done);
    end
endtask

////////////////////////////////////////////////////////////
// Issue and wait

// Holds the request until accepted, returns one cycle after acceptance
task automatic issue_op(input ls_instr_u ins, input logic [31:0] a, input logic [31:0] b,
                        output logic [`LSU_ID_W-1:0] id, output int acc);
    int n;
    id          = next_id;
    next_id     = next_id + 1'b1;
    instr       = ins;
    rs1_data    = a;
    rs2_data    = b;
    issue_id    = id;
    issue_valid = 1'b1;
    n = 0;
    while (!issue_ready && n < TIMEOUT) begin
        step();
        n++;
    end
    if (!issue_ready) begin
        timeouts++;
        $display("Timeout at %0t, issue_ready stayed low for %0d cycles", $time, TIMEOUT);
    end
    acc = cyc;
    step();
    issue_valid = 1'b0;
endtask

task automatic wait_wb(output logic [`LSU_ID_W-1:0] id, output logic [31:0] data,
                       output int done);
    int n;
    n = 0;
    while (!wb_done && n < TIMEOUT) begin
        step();
        n++;
    end
    if (!wb_done) begin
        timeouts++;
        $display("Timeout at %0t, no load writeback within %0d cycles", $time, TIMEOUT);
    end
    id   = wb_id;
    data = wb_data;
    done = cyc;
    step();
endtask

task automatic wait_exc(output ls_exc_code_e code, output logic [31:0] tval,
                        output logic [`LSU_ID_W-1:0] id);
    int n;
    n = 0;
    while (!exc_valid && n < TIMEOUT) begin
        step();
        n++;
    end
    if (!exc_valid) begin
        timeouts++;
        $display("Timeout at %0t, no exception within %0d cycles", $time, TIMEOUT);
    end
    code = exc_code;
    tval = exc_tval;
    id   = exc_id;
    step();
endtask

// A faulting access must never write back
task automatic expect_no_wb(input int cycles);
    for (int n = 0; n < cycles; n++) begin
        if (wb_done) begin
            errors++;
            $display("Unexpected load writeback at %0t after a faulting access", $time);
        end
        step();
    end
endtask

`endif

// ==== tests/tb_load_store_unit.sv ====
// Directed testbench for the load/store unit
// Loads are only checked at bytes that the test has written before
`timescale 1ns/10ps
`default_nettype none

`include "lsu_settings.svh"

module tb_load_store_unit
    import lsu_pkg::*;
();
    localparam int TIMEOUT = 20;

    logic                 clk;
    logic                 rst;
    logic                 issue_valid;
    logic                 issue_ready;
    ls_instr_u            instr;
    logic [31:0]          rs1_data;
    logic [31:0]          rs2_data;
    logic [`LSU_ID_W-1:0] issue_id;
    logic                 wb_done;
    logic [`LSU_ID_W-1:0] wb_id;
    logic [31:0]          wb_data;
    logic                 exc_valid;
    ls_exc_code_e         exc_code;
    logic [31:0]          exc_tval;
    logic [`LSU_ID_W-1:0] exc_id;
    logic                 idle;

    int                   cyc = 0;
    int                   checks = 0;
    int                   errors = 0;
    int                   timeouts = 0;
    logic [`LSU_ID_W-1:0] next_id = '0;
    logic [31:0]          lfsr = 32'd10;
    // Expected memory contents, one byte per lane
    logic [7:0]           ref_mem [`LSU_MEM_BYTES/4][4];

    load_store_unit uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    `include "tb_lsu_tasks.svh"

    ////////////////////////////////////////////////////////////
    // Stimulus helpers

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int k = 0; k < n; k++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b)
                lfsr = lfsr ^ 32'h8020_0003;
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] rand_word_addr(input int bank);
        return 32'(bank) * (32'd1 << `LSU_BANK_SEL_LSB) + (rand_bits(`LSU_BANK_ADDR_W) << 2);
    endfunction

    function automatic ls_instr_u enc_i(input logic [6:0] op, input logic [2:0] f,
                                        input logic [11:0] imm);
        ls_instr_u w;
        w.i.imm12  = imm;
        w.i.rs1    = 5'd10;
        w.i.fn3    = ls_fn3_e'(f);
        w.i.rd     = 5'd11;
        w.i.opcode = op;
        return w;
    endfunction

    function automatic ls_instr_u enc_s(input logic [2:0] f, input logic [11:0] imm);
        ls_instr_u w;
        w.s.imm_hi = imm[11:5];
        w.s.rs2    = 5'd12;
        w.s.rs1    = 5'd10;
        w.s.fn3    = ls_fn3_e'(f);
        w.s.imm_lo = imm[4:0];
        w.s.opcode = OP_STORE;
        return w;
    endfunction

    // Lane select and extension from the reference memory
    function automatic logic [31:0] load_expect(input logic [2:0] f, input logic [31:0] addr);
        logic [7:0] b;
        int         w;
        int         o;
        w = int'(addr >> 2);
        o = int'(addr[1:0]);
        b = ref_mem[w][o];
        case (f)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'd0, b};
            LH:      return {{16{ref_mem[w][o+1][7]}}, ref_mem[w][o+1], b};
            LHU:     return {16'd0, ref_mem[w][o+1], b};
            default: return {ref_mem[w][3], ref_mem[w][2], ref_mem[w][1], ref_mem[w][0]};
        endcase
    endfunction

    task automatic do_store(input logic [2:0] f, input logic [31:0] addr, input logic [31:0] data);
        logic [11:0]          imm;
        logic [`LSU_ID_W-1:0] id;
        int                   acc;
        int                   w;
        int                   o;
        imm = 12'(rand_bits(5) << 2);
        issue_op(enc_s(f, imm), addr - 32'(imm), data, id, acc);
        w = int'(addr >> 2);
        o = int'(addr[1:0]);
        ref_mem[w][o] = data[7:0];
        if (f != SB)
            ref_mem[w][o+1] = data[15:8];
        if (f == SW) begin
            ref_mem[w][2] = data[23:16];
            ref_mem[w][3] = data[31:24];
        end
    endtask

    task automatic do_load(input logic [2:0] f, input logic [31:0] addr);
        logic [11:0]          imm;
        logic [`LSU_ID_W-1:0] id;
        logic [`LSU_ID_W-1:0] got_id;
        logic [31:0]          got_data;
        int                   acc;
        int                   done;
        imm = 12'(rand_bits(5) << 2);
        issue_op(enc_i(OP_LOAD, f, imm), addr - 32'(imm), 32'h0, id, acc);
        wait_wb(got_id, got_data, done);
        check_data("wb_data", got_data, load_expect(f, addr));
        check_id("wb_id", got_id, id);
        check_latency(acc, done);
    endtask

    task automatic exc_case(input ls_instr_u ins, input logic [31:0] rs1, input ls_exc_code_e code,
                            input logic has_tval, input logic [31:0] tval);
        logic [`LSU_ID_W-1:0] id;
        logic [`LSU_ID_W-1:0] got_id;
        ls_exc_code_e         got_code;
        logic [31:0]          got_tval;
        int                   acc;
        issue_op(ins, rs1, 32'hDEAD_BEEF, id, acc);
        wait_exc(got_code, got_tval, got_id);
        check_exc("exc_code", got_code, code);
        if (has_tval)
            check_data("exc_tval", got_tval, tval);
        check_id("exc_id", got_id, id);
        expect_no_wb(3);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_word_access();
        logic [31:0] a;
        for (int b = 0; b < `LSU_NUM_BANKS; b++) begin
            a = rand_word_addr(b);
            do_store(SW, a, rand_bits(32));
            do_load(LW, a);
        end
    endtask

    task automatic test_sub_word();
        logic [7:0]  byte_val [2];
        logic [15:0] half_val [2];
        logic [31:0] a;
        byte_val = '{8'h85, 8'h5A};
        half_val = '{16'h80F0, 16'h7F3C};
        for (int k = 0; k < 2; k++) begin
            a = rand_word_addr(k + 1);
            do_store(SW, a, rand_bits(32));
            do_store(SH, a + 2, {16'hC3C3, half_val[k]});
            do_store(SB, a + 1, {24'hA5A5A5, byte_val[k]});
            for (int o = 0; o < 4; o++) begin
                do_load(LB, a + o);
                do_load(LBU, a + o);
            end
            for (int o = 0; o < 4; o += 2) begin
                do_load(LH, a + o);
                do_load(LHU, a + o);
            end
        end
    endtask

    task automatic test_back_to_back();
        logic [31:0]          a0;
        logic [31:0]          a1;
        logic [`LSU_ID_W-1:0] id0;
        logic [`LSU_ID_W-1:0] id1;
        logic [`LSU_ID_W-1:0] got_id;
        logic [31:0]          got_data;
        int                   acc0;
        int                   acc1;
        int                   done;
        a0 = rand_word_addr(0);
        a1 = rand_word_addr(`LSU_NUM_BANKS - 1);
        do_store(SW, a0, rand_bits(32));
        do_store(SW, a1, rand_bits(32));
        issue_op(enc_i(OP_LOAD, LW, 12'd0), a0, 32'h0, id0, acc0);
        issue_op(enc_i(OP_LOAD, LW, 12'd0), a1, 32'h0, id1, acc1);
        wait_wb(got_id, got_data, done);
        check_data("wb_data", got_data, load_expect(LW, a0));
        check_id("wb_id", got_id, id0);
        check_latency(acc0, done);
        wait_wb(got_id, got_data, done);
        check_data("wb_data", got_data, load_expect(LW, a1));
        check_id("wb_id", got_id, id1);
        check_latency(acc1, done);
    endtask

    task automatic test_misaligned();
        logic [31:0] a;
        a = rand_word_addr(1);
        do_store(SW, a, rand_bits(32));
        exc_case(enc_i(OP_LOAD, LH, 12'd1), a, LOAD_ADDR_MISALIGNED, 1'b1, a + 1);
        exc_case(enc_i(OP_LOAD, LW, 12'd2), a, LOAD_ADDR_MISALIGNED, 1'b1, a + 2);
        exc_case(enc_s(SW, 12'hFFF), a + 4, STORE_ADDR_MISALIGNED, 1'b1, a + 3);
        exc_case(enc_s(SH, 12'd1), a, STORE_ADDR_MISALIGNED, 1'b1, a + 1);
        // Word must be untouched by the rejected stores
        do_load(LW, a);
    endtask

    task automatic test_faults();
        exc_case(enc_i(OP_LOAD, LW, 12'd4), 32'(`LSU_MEM_BYTES) - 4, LOAD_ACCESS_FAULT,
                 1'b1, 32'(`LSU_MEM_BYTES));
        exc_case(enc_s(SB, 12'd0), 32'h8000_0001, STORE_ACCESS_FAULT, 1'b1, 32'h8000_0001);
        exc_case(enc_i(OP_LOAD, 3'b011, 12'd0), 32'h0, ILLEGAL_INST, 1'b0, 32'h0);
        exc_case(enc_s(3'b100, 12'd0), 32'h0, ILLEGAL_INST, 1'b0, 32'h0);
    endtask

    task automatic test_fence();
        logic [31:0]          a;
        logic [`LSU_ID_W-1:0] id;
        logic [`LSU_ID_W-1:0] fence_id;
        logic                 seen;
        int                   acc;
        int                   n;
        a = rand_word_addr(2);
        do_store(SW, a, rand_bits(32));
        issue_op(enc_i(OP_LOAD, LW, 12'd0), a, 32'h0, id, acc);
        issue_op(enc_i(OP_FENCE, 3'b000, 12'd0), 32'h0, 32'h0, fence_id, acc);
        if (issue_ready) begin
            errors++;
            $display("issue_ready still high at %0t after an accepted FENCE", $time);
        end
        // Load still in flight
        check_flag("idle", idle, 1'b0);
        seen = 1'b0;
        n = 0;
        while (!issue_ready && n < TIMEOUT) begin
            if (wb_done) begin
                seen = 1'b1;
                check_data("wb_data", wb_data, load_expect(LW, a));
                check_id("wb_id", wb_id, id);
            end
            step();
            n++;
        end
        if (!issue_ready) begin
            timeouts++;
            $display("Timeout at %0t, issue_ready stayed low after the FENCE", $time);
        end
        if (!seen) begin
            errors++;
            $display("issue_ready returned before the load ahead of the FENCE wrote back");
        end
        check_flag("idle", idle, 1'b1);
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence

    initial begin
        rst         = 1'b1;
        issue_valid = 1'b0;
        instr       = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        issue_id    = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        #1;
        if (wb_done || exc_valid) begin
            errors++;
            $display("Writeback or exception active right after reset");
        end
        check_flag("issue_ready", issue_ready, 1'b1);
        check_flag("idle", idle, 1'b1);
        step();
        test_word_access();
        test_sub_word();
        test_back_to_back();
        test_misaligned();
        test_faults();
        test_fence();
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/data_bank.sv ====
// Byte-writable word memory with one-cycle read latency
// Contents are undefined until written
`timescale 1ns/10ps
`default_nettype none

`include "lsu_settings.svh"

module data_bank (
    input  logic                        clk,
    input  logic                        req,
    input  logic                        we,
    input  logic [3:0]                  be,
    input  logic [`LSU_BANK_ADDR_W-1:0] word_addr,
    input  logic [31:0]                 wdata,
    output logic [31:0]                 rdata
);
    logic [31:0] mem [`LSU_BANK_WORDS];

    // Writes merge by byte lane
    // Reads hold their data until the next read request
    always_ff @(posedge clk) begin
        if (req) begin
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b])
                        mem[word_addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end else begin
                rdata <= mem[word_addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/load_store_unit.sv ====
// Load/store unit top with the issue stage, the data banks and load writeback
// A load takes two cycles to writeback and a store writes one cycle after acceptance
`timescale 1ns/10ps
`default_nettype none

`include "lsu_settings.svh"

module load_store_unit
    import lsu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // Issue
    input  logic                 issue_valid,
    output logic                 issue_ready,
    input  ls_instr_u            instr,
    input  logic [31:0]          rs1_data,
    input  logic [31:0]          rs2_data,
    input  logic [`LSU_ID_W-1:0] issue_id,
    // Writeback
    output logic                 wb_done,
    output logic [`LSU_ID_W-1:0] wb_id,
    output logic [31:0]          wb_data,
    // Exceptions
    output logic                 exc_valid,
    output ls_exc_code_e         exc_code,
    output logic [31:0]          exc_tval,
    output logic [`LSU_ID_W-1:0] exc_id,
    // Status
    output logic                 idle
);
    logic [`LSU_NUM_BANKS-1:0]   bank_req;
    logic                        bank_we;
    logic [3:0]                  bank_be;
    logic [`LSU_BANK_ADDR_W-1:0] bank_word_addr;
    logic [31:0]                 bank_wdata;
    logic [31:0]                 bank_rdata [`LSU_NUM_BANKS];
    logic                        attr_push;
    load_attr_t                  attr_data;

    ls_issue u_issue (
        .clk            (clk),
        .rst            (rst),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .instr          (instr),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .issue_id       (issue_id),
        .idle           (idle),
        .bank_req       (bank_req),
        .bank_we        (bank_we),
        .bank_be        (bank_be),
        .bank_word_addr (bank_word_addr),
        .bank_wdata     (bank_wdata),
        .attr_push      (attr_push),
        .attr_data      (attr_data),
        .exc_valid      (exc_valid),
        .exc_code       (exc_code),
        .exc_tval       (exc_tval),
        .exc_id         (exc_id)
    );

    // Request fields are shared and only the addressed bank sees req
    for (genvar i = 0; i < `LSU_NUM_BANKS; i++) begin : gen_bank
        data_bank u_bank (
            .clk       (clk),
            .req       (bank_req[i]),
            .we        (bank_we),
            .be        (bank_be),
            .word_addr (bank_word_addr),
            .wdata     (bank_wdata),
            .rdata     (bank_rdata[i])
        );
    end

    load_writeback u_wb (
        .clk        (clk),
        .rst        (rst),
        .attr_push  (attr_push),
        .attr_data  (attr_data),
        .bank_rdata (bank_rdata),
        .wb_done    (wb_done),
        .wb_id      (wb_id),
        .wb_data    (wb_data),
        .idle       (idle)
    );

endmodule

`default_nettype wire

// ==== verilog/load_writeback.sv ====
// Finishes loads in order, one per cycle, with no back-pressure on writeback
// FIFO depth must cover every load in flight since a push is never refused
`timescale 1ns/10ps
`default_nettype none

`include "lsu_settings.svh"

module load_writeback
    import lsu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 attr_push,
    input  load_attr_t           attr_data,
    input  logic [31:0]          bank_rdata [`LSU_NUM_BANKS],
    output logic                 wb_done,
    output logic [`LSU_ID_W-1:0] wb_id,
    output logic [31:0]          wb_data,
    output logic                 idle
);
    localparam int PTR_W = (`LSU_ATTR_DEPTH > 1) ? $clog2(`LSU_ATTR_DEPTH) : 1;

    load_attr_t        attr_mem [`LSU_ATTR_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              data_valid;
    load_attr_t        head;
    logic [31:0]       word;
    logic [31:0]       shifted;
    logic              sign_bit;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`LSU_ATTR_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Attribute FIFO

    always_ff @(posedge clk) begin
        if (attr_push)
            attr_mem[wr_ptr] <= attr_data;
    end

    // The push is seen one cycle before the bank data arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            data_valid <= 1'b0;
        end else begin
            data_valid <= attr_push;
            if (attr_push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (data_valid)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({attr_push, data_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head = attr_mem[rd_ptr];

    ////////////////////////////////////////////////////////////
    // Result alignment

    assign word    = bank_rdata[head.bank_id];
    assign shifted = word >> {head.byte_addr, 3'b000};

    always_comb begin
        case (head.size)
            2'd0:    sign_bit = head.is_signed & shifted[7];
            2'd1:    sign_bit = head.is_signed & shifted[15];
            default: sign_bit = 1'b0;
        endcase
    end

    always_comb begin
        case (head.size)
            2'd0:    wb_data = {{24{sign_bit}}, shifted[7:0]};
            2'd1:    wb_data = {{16{sign_bit}}, shifted[15:0]};
            default: wb_data = word;
        endcase
    end

    assign wb_done = data_valid;
    assign wb_id   = head.id;

    // Stores finish at the bank the cycle after issue, so only loads stay outstanding
    assign idle = (count == '0) && !attr_push;

endmodule

`default_nettype wire

// ==== verilog/ls_issue.sv ====
// One load, store or FENCE is accepted per cycle and its bank access is registered
// Faulting accesses never reach a bank. No memory exists at or above LSU_MEM_BYTES
`timescale 1ns/10ps
`default_nettype none

`include "lsu_settings.svh"

module ls_issue
    import lsu_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue_valid,
    output logic                        issue_ready,
    input  ls_instr_u                   instr,
    input  logic [31:0]                 rs1_data,
    input  logic [31:0]                 rs2_data,
    input  logic [`LSU_ID_W-1:0]        issue_id,
    input  logic                        idle,
    output logic [`LSU_NUM_BANKS-1:0]   bank_req,
    output logic                        bank_we,
    output logic [3:0]                  bank_be,
    output logic [`LSU_BANK_ADDR_W-1:0] bank_word_addr,
    output logic [31:0]                 bank_wdata,
    output logic                        attr_push,
    output load_attr_t                  attr_data,
    output logic                        exc_valid,
    output ls_exc_code_e                exc_code,
    output logic [31:0]                 exc_tval,
    output logic [`LSU_ID_W-1:0]        exc_id
);
    logic                       is_load;
    logic                       is_store;
    logic                       is_fence;
    logic [2:0]                 fn3;
    logic                       fn3_ok;
    logic                       illegal;
    logic [11:0]                offset;
    logic [31:0]                addr;
    logic [1:0]                 size;
    logic                       misaligned;
    logic                       out_of_range;
    logic                       fault;
    logic                       accept;
    logic                       do_access;
    logic                       fence_hold;
    logic [3:0]                 be;
    logic [31:0]                wdata;
    logic [`LSU_BANK_IDX_W-1:0] bank_idx;
    logic [`LSU_NUM_BANKS-1:0]  req_onehot;
    ls_exc_code_e               next_code;

    ////////////////////////////////////////////////////////////
    // Decode

    assign is_load  = instr.i.opcode == OP_LOAD;
    assign is_store = instr.s.opcode == OP_STORE;
    assign is_fence = instr.i.opcode == OP_FENCE;
    assign fn3      = instr.i.fn3;
    assign size     = fn3[1:0];

    always_comb begin
        fn3_ok = 1'b0;
        if (is_load)
            fn3_ok = fn3 inside {LB, LH, LW, LBU, LHU};
        else if (is_store)
            fn3_ok = fn3 inside {SB, SH, SW};
        else if (is_fence)
            fn3_ok = fn3 == 3'b000;
    end

    // Unknown opcodes land here as well
    assign illegal = ~fn3_ok;

    ////////////////////////////////////////////////////////////
    // Address and checks

    assign offset = is_store ? {instr.s.imm_hi, instr.s.imm_lo} : instr.i.imm12;
    assign addr   = rs1_data + {{20{offset[11]}}, offset};

    assign misaligned   = (size == 2'd1 && addr[0]) || (size == 2'd2 && addr[1:0] != 2'b00);
    assign out_of_range = addr >= 32'(`LSU_MEM_BYTES);
    assign fault        = illegal || ((is_load || is_store) && (misaligned || out_of_range));

    always_comb begin
        if (illegal)
            next_code = ILLEGAL_INST;
        else if (misaligned)
            next_code = is_store ? STORE_ADDR_MISALIGNED : LOAD_ADDR_MISALIGNED;
        else
            next_code = is_store ? STORE_ACCESS_FAULT : LOAD_ACCESS_FAULT;
    end

    // Closed in reset and while a FENCE waits for idle
    assign issue_ready = ~fence_hold && ~rst;
    assign accept      = issue_valid && issue_ready;
    assign do_access   = accept && !fault && (is_load || is_store);

    ////////////////////////////////////////////////////////////
    // Bank request

    assign bank_idx = addr[`LSU_BANK_SEL_LSB +: `LSU_BANK_IDX_W];

    always_comb begin
        for (int i = 0; i < `LSU_NUM_BANKS; i++)
            req_onehot[i] = do_access && (bank_idx == i);
    end

    // Byte enables and store data replicated into every lane
    always_comb begin
        case (size)
            2'd0: begin
                be    = 4'b0001 << addr[1:0];
                wdata = {4{rs2_data[7:0]}};
            end
            2'd1: begin
                be    = 4'b0011 << addr[1:0];
                wdata = {2{rs2_data[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wdata = rs2_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bank_req   <= '0;
            attr_push  <= 1'b0;
            exc_valid  <= 1'b0;
            fence_hold <= 1'b0;
        end else begin
            bank_req   <= req_onehot;
            attr_push  <= do_access && is_load;
            exc_valid  <= accept && fault;
            fence_hold <= (fence_hold && !idle) || (accept && is_fence && !illegal);
        end
    end

    always_ff @(posedge clk) begin
        if (do_access) begin
            bank_we        <= is_store;
            bank_be        <= be;
            bank_word_addr <= addr[2 +: `LSU_BANK_ADDR_W];
            bank_wdata     <= wdata;
            attr_data      <= '{
                is_signed: ~fn3[2],
                byte_addr: addr[1:0],
                size:      size,
                bank_id:   bank_idx,
                id:        issue_id
            };
        end
        if (accept) begin
            exc_code <= next_code;
            exc_tval <= illegal ? instr : addr;
            exc_id   <= issue_id;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_pkg.sv ====
// Types shared by the load/store unit blocks
// Only the RV32I integer loads, stores and FENCE are encoded here
`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

    ////////////////////////////////////////////////////////////
    // Instruction encodings

    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_FENCE = 7'b0001111;

    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } ls_fn3_e;

    // Stores reuse the size codes of the signed loads
    localparam ls_fn3_e SB = LB;
    localparam ls_fn3_e SH = LH;
    localparam ls_fn3_e SW = LW;

    typedef enum logic [4:0] {
        ILLEGAL_INST          = 5'd2,
        LOAD_ADDR_MISALIGNED  = 5'd4,
        LOAD_ACCESS_FAULT     = 5'd5,
        STORE_ADDR_MISALIGNED = 5'd6,
        STORE_ACCESS_FAULT    = 5'd7
    } ls_exc_code_e;

    ////////////////////////////////////////////////////////////
    // Instruction word views

    // Loads and FENCE
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        ls_fn3_e     fn3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } ls_i_fmt_t;

    // Stores, immediate split around rs2
    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        ls_fn3_e     fn3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } ls_s_fmt_t;

    typedef union packed {
        ls_i_fmt_t i;
        ls_s_fmt_t s;
    } ls_instr_u;

    // What writeback needs to finish one load
    typedef struct packed {
        logic                       is_signed;
        logic [1:0]                 byte_addr;
        logic [1:0]                 size;
        logic [`LSU_BANK_IDX_W-1:0] bank_id;
        logic [`LSU_ID_W-1:0]       id;
    } load_attr_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_settings.svh ====
// Sizes of the load/store unit memory map and its load tracking
// Banks must tile LSU_MEM_BYTES exactly and the bank count must be a power of two
// LSU_BANK_SEL_LSB must equal 2 plus the word address width of one bank
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Memory map
`define LSU_NUM_BANKS     4
`define LSU_BANK_WORDS    256
`define LSU_BANK_SEL_LSB  10
`define LSU_MEM_BYTES     4096

// Widths derived from the map
`define LSU_BANK_IDX_W    $clog2(`LSU_NUM_BANKS)
`define LSU_BANK_ADDR_W   $clog2(`LSU_BANK_WORDS)

// Loads in flight, matches the two-cycle load latency
`define LSU_ATTR_DEPTH    2

// Instruction tag carried to writeback and exceptions
`define LSU_ID_W          4

`endif
